//--- src/ec_defines.svh
`ifndef EC_DEFINES_SVH
`define EC_DEFINES_SVH

// Bitstream window width in bits.
`define EC_WINDOW_W     16

// Golomb-Rice suffix length.
`define EC_GRK          5

// Largest unary prefix for the two-bit sample mode.
`define EC_MAX_PREFIX   7

// Leading window bits searched for the prefix.
`define EC_PREFIX_LOOK  8

`endif

//--- src/ec_pkg.sv
package ec_pkg;

  // Picks the inverse table.
  typedef enum logic
  {
    COMP_CHROMA = 1'b0,
    COMP_LUMA   = 1'b1
  } component_e;

  typedef logic [7:0] code_num_t;  // Inverse table index.
  typedef logic [7:0] symbol_t;    // Four packed samples.
  typedef logic [1:0] sample_t;

  // Bits consumed from the window.
  typedef logic [3:0] size_t;

endpackage

//--- src/ec_prefix_decoder.sv
`timescale 1ns/100ps
`include "ec_defines.svh"

module ec_prefix_decoder
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`EC_WINDOW_W-1:0] window,
  input  ec_pkg::component_e      component,
  output ec_pkg::code_num_t       code_num,
  output ec_pkg::size_t           size,
  output ec_pkg::component_e      component_q
);

  logic [3:0]              ones_cnt;
  logic                    run;
  logic [2:0]              prefix;
  logic [3:0]              prefix_len;
  logic [`EC_WINDOW_W-1:0] window_sh;
  logic [`EC_GRK-1:0]      gr_low;
  ec_pkg::code_num_t       code_num_d;
  ec_pkg::size_t           size_d;

  // Leading ones of the window, MSB first.
  always_comb
  begin
    ones_cnt = '0;
    run      = 1'b1;
    for (int i = 0; i < `EC_PREFIX_LOOK; i++)
    begin
      run      = run & window[`EC_WINDOW_W-1-i];
      ones_cnt = ones_cnt + {3'b000, run};
    end
  end

  assign prefix = (ones_cnt > 4'(`EC_MAX_PREFIX)) ? 3'(`EC_MAX_PREFIX) : ones_cnt[2:0];

  // No terminating zero at the clip value.
  assign prefix_len = (prefix == 3'(`EC_MAX_PREFIX)) ? {1'b0, prefix}
                                                      : {1'b0, prefix} + 4'd1;

  assign window_sh  = window << prefix_len;
  assign gr_low     = window_sh[`EC_WINDOW_W-1 -: `EC_GRK];
  assign code_num_d = {prefix, gr_low};  // Prefix times 32 plus suffix.
  assign size_d     = prefix_len + 4'(`EC_GRK);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      code_num    <= '0;
      size        <= '0;
      component_q <= ec_pkg::COMP_CHROMA;
    end
    else
    begin
      code_num    <= code_num_d;
      size        <= size_d;
      component_q <= component;
    end
  end

  // Code spans 6 to 12 bits and is 6 only after a leading zero.
  a_size_range: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (size >= 4'd6 && size <= 4'd12)
                     && ((size == 4'd6) == !$past(window[`EC_WINDOW_W-1])));

endmodule

//--- src/ec_symbol_lut.sv
`timescale 1ns/100ps
`include "ec_defines.svh"

module ec_symbol_lut
(
  input  logic               clk,
  input  logic               rst_n,
  input  ec_pkg::code_num_t  code_num,
  input  ec_pkg::size_t      size_in,
  input  ec_pkg::component_e component,
  output ec_pkg::symbol_t    symbol,
  output ec_pkg::size_t      size,
  output ec_pkg::sample_t    sample_0,
  output ec_pkg::sample_t    sample_1,
  output ec_pkg::sample_t    sample_2,
  output ec_pkg::sample_t    sample_3
);

  ec_pkg::symbol_t sym_l;
  ec_pkg::symbol_t sym_c;
  ec_pkg::symbol_t sym_t;
  ec_pkg::symbol_t sym_sel;

  // Codes 240 to 255 map alike in both tables.
  always_comb
  begin
    case (code_num[3:0])
      0: sym_t = 8'd85;   1: sym_t = 8'd21;   2: sym_t = 8'd69;   3: sym_t = 8'd5;
      4: sym_t = 8'd81;   5: sym_t = 8'd17;   6: sym_t = 8'd65;   7: sym_t = 8'd1;
      8: sym_t = 8'd84;   9: sym_t = 8'd20;   10: sym_t = 8'd68;  11: sym_t = 8'd4;
      12: sym_t = 8'd80;  13: sym_t = 8'd16;  14: sym_t = 8'd64;  15: sym_t = 8'd0;
    endcase
  end

  // Luma inverse table.
  always_comb
  begin
    case (code_num)
      0: sym_l = 8'd8;  1: sym_l = 8'd2;  2: sym_l = 8'd128;  3: sym_l = 8'd32;
      4: sym_l = 8'd6;  5: sym_l = 8'd9;  6: sym_l = 8'd18;  7: sym_l = 8'd72;
      8: sym_l = 8'd132;  9: sym_l = 8'd33;  10: sym_l = 8'd66;  11: sym_l = 8'd24;
      12: sym_l = 8'd129;  13: sym_l = 8'd36;  14: sym_l = 8'd144;  15: sym_l = 8'd96;
      16: sym_l = 8'd22;  17: sym_l = 8'd73;  18: sym_l = 8'd12;  19: sym_l = 8'd3;
      20: sym_l = 8'd25;  21: sym_l = 8'd70;  22: sym_l = 8'd88;  23: sym_l = 8'd82;
      24: sym_l = 8'd37;  25: sym_l = 8'd133;  26: sym_l = 8'd148;  27: sym_l = 8'd97;
      28: sym_l = 8'd192;  29: sym_l = 8'd48;  30: sym_l = 8'd145;  31: sym_l = 8'd100;
      32: sym_l = 8'd86;  33: sym_l = 8'd89;  34: sym_l = 8'd10;  35: sym_l = 8'd34;
      36: sym_l = 8'd136;  37: sym_l = 8'd149;  38: sym_l = 8'd101;  39: sym_l = 8'd13;
      40: sym_l = 8'd7;  41: sym_l = 8'd76;  42: sym_l = 8'd19;  43: sym_l = 8'd160;
      44: sym_l = 8'd40;  45: sym_l = 8'd49;  46: sym_l = 8'd28;  47: sym_l = 8'd67;
      48: sym_l = 8'd130;  49: sym_l = 8'd196;  50: sym_l = 8'd112;  51: sym_l = 8'd208;
      52: sym_l = 8'd52;  53: sym_l = 8'd193;  54: sym_l = 8'd74;  55: sym_l = 8'd38;
      56: sym_l = 8'd26;  57: sym_l = 8'd137;  58: sym_l = 8'd98;  59: sym_l = 8'd152;
      60: sym_l = 8'd77;  61: sym_l = 8'd41;  62: sym_l = 8'd23;  63: sym_l = 8'd83;
      64: sym_l = 8'd71;  65: sym_l = 8'd29;  66: sym_l = 8'd92;  67: sym_l = 8'd90;
      68: sym_l = 8'd134;  69: sym_l = 8'd164;  70: sym_l = 8'd153;  71: sym_l = 8'd146;
      72: sym_l = 8'd104;  73: sym_l = 8'd161;  74: sym_l = 8'd113;  75: sym_l = 8'd102;
      76: sym_l = 8'd53;  77: sym_l = 8'd197;  78: sym_l = 8'd212;  79: sym_l = 8'd209;
      80: sym_l = 8'd116;  81: sym_l = 8'd165;  82: sym_l = 8'd14;  83: sym_l = 8'd150;
      84: sym_l = 8'd11;  85: sym_l = 8'd35;  86: sym_l = 8'd93;  87: sym_l = 8'd105;
      88: sym_l = 8'd50;  89: sym_l = 8'd87;  90: sym_l = 8'd140;  91: sym_l = 8'd200;
      92: sym_l = 8'd117;  93: sym_l = 8'd213;  94: sym_l = 8'd176;  95: sym_l = 8'd224;
      96: sym_l = 8'd131;  97: sym_l = 8'd44;  98: sym_l = 8'd194;  99: sym_l = 8'd56;
      100: sym_l = 8'd39;  101: sym_l = 8'd138;  102: sym_l = 8'd27;  103: sym_l = 8'd42;
      104: sym_l = 8'd201;  105: sym_l = 8'd162;  106: sym_l = 8'd78;  107: sym_l = 8'd168;
      108: sym_l = 8'd141;  109: sym_l = 8'd30;  110: sym_l = 8'd75;  111: sym_l = 8'd106;
      112: sym_l = 8'd114;  113: sym_l = 8'd54;  114: sym_l = 8'd156;  115: sym_l = 8'd99;
      116: sym_l = 8'd166;  117: sym_l = 8'd154;  118: sym_l = 8'd216;  119: sym_l = 8'd169;
      120: sym_l = 8'd15;  121: sym_l = 8'd198;  122: sym_l = 8'd177;  123: sym_l = 8'd170;
      124: sym_l = 8'd210;  125: sym_l = 8'd45;  126: sym_l = 8'd57;  127: sym_l = 8'd217;
      128: sym_l = 8'd108;  129: sym_l = 8'd228;  130: sym_l = 8'd204;  131: sym_l = 8'd103;
      132: sym_l = 8'd147;  133: sym_l = 8'd120;  134: sym_l = 8'd135;  135: sym_l = 8'd51;
      136: sym_l = 8'd91;  137: sym_l = 8'd225;  138: sym_l = 8'd180;  139: sym_l = 8'd94;
      140: sym_l = 8'd157;  141: sym_l = 8'd151;  142: sym_l = 8'd229;  143: sym_l = 8'd121;
      144: sym_l = 8'd118;  145: sym_l = 8'd109;  146: sym_l = 8'd181;  147: sym_l = 8'd240;
      148: sym_l = 8'd214;  149: sym_l = 8'd195;  150: sym_l = 8'd79;  151: sym_l = 8'd60;
      152: sym_l = 8'd205;  153: sym_l = 8'd55;  154: sym_l = 8'd31;  155: sym_l = 8'd220;
      156: sym_l = 8'd43;  157: sym_l = 8'd115;  158: sym_l = 8'd119;  159: sym_l = 8'd142;
      160: sym_l = 8'd163;  161: sym_l = 8'd178;  162: sym_l = 8'd221;  163: sym_l = 8'd139;
      164: sym_l = 8'd202;  165: sym_l = 8'd107;  166: sym_l = 8'd232;  167: sym_l = 8'd58;
      168: sym_l = 8'd244;  169: sym_l = 8'd199;  170: sym_l = 8'd158;  171: sym_l = 8'd46;
      172: sym_l = 8'd155;  173: sym_l = 8'd241;  174: sym_l = 8'd95;  175: sym_l = 8'd184;
      176: sym_l = 8'd172;  177: sym_l = 8'd226;  178: sym_l = 8'd122;  179: sym_l = 8'd124;
      180: sym_l = 8'd61;  181: sym_l = 8'd211;  182: sym_l = 8'd182;  183: sym_l = 8'd233;
      184: sym_l = 8'd245;  185: sym_l = 8'd185;  186: sym_l = 8'd173;  187: sym_l = 8'd110;
      188: sym_l = 8'd167;  189: sym_l = 8'd218;  190: sym_l = 8'd230;  191: sym_l = 8'd215;
      192: sym_l = 8'd125;  193: sym_l = 8'd47;  194: sym_l = 8'd186;  195: sym_l = 8'd174;
      196: sym_l = 8'd206;  197: sym_l = 8'd143;  198: sym_l = 8'd171;  199: sym_l = 8'd203;
      200: sym_l = 8'd234;  201: sym_l = 8'd111;  202: sym_l = 8'd179;  203: sym_l = 8'd59;
      204: sym_l = 8'd62;  205: sym_l = 8'd246;  206: sym_l = 8'd236;  207: sym_l = 8'd242;
      208: sym_l = 8'd222;  209: sym_l = 8'd237;  210: sym_l = 8'd183;  211: sym_l = 8'd126;
      212: sym_l = 8'd248;  213: sym_l = 8'd123;  214: sym_l = 8'd249;  215: sym_l = 8'd231;
      216: sym_l = 8'd159;  217: sym_l = 8'd219;  218: sym_l = 8'd227;  219: sym_l = 8'd188;
      220: sym_l = 8'd189;  221: sym_l = 8'd187;  222: sym_l = 8'd250;  223: sym_l = 8'd63;
      224: sym_l = 8'd207;  225: sym_l = 8'd175;  226: sym_l = 8'd223;  227: sym_l = 8'd238;
      228: sym_l = 8'd247;  229: sym_l = 8'd235;  230: sym_l = 8'd253;  231: sym_l = 8'd127;
      232: sym_l = 8'd252;  233: sym_l = 8'd190;  234: sym_l = 8'd243;  235: sym_l = 8'd239;
      236: sym_l = 8'd191;  237: sym_l = 8'd254;  238: sym_l = 8'd255;  239: sym_l = 8'd251;
      default: sym_l = sym_t;
    endcase
  end

  // Chroma inverse table.
  always_comb
  begin
    case (code_num)
      0: sym_c = 8'd2;  1: sym_c = 8'd8;  2: sym_c = 8'd128;  3: sym_c = 8'd32;
      4: sym_c = 8'd6;  5: sym_c = 8'd9;  6: sym_c = 8'd18;  7: sym_c = 8'd72;
      8: sym_c = 8'd96;  9: sym_c = 8'd144;  10: sym_c = 8'd33;  11: sym_c = 8'd132;
      12: sym_c = 8'd10;  13: sym_c = 8'd24;  14: sym_c = 8'd66;  15: sym_c = 8'd129;
      16: sym_c = 8'd22;  17: sym_c = 8'd36;  18: sym_c = 8'd73;  19: sym_c = 8'd160;
      20: sym_c = 8'd25;  21: sym_c = 8'd70;  22: sym_c = 8'd97;  23: sym_c = 8'd82;
      24: sym_c = 8'd88;  25: sym_c = 8'd148;  26: sym_c = 8'd86;  27: sym_c = 8'd37;
      28: sym_c = 8'd89;  29: sym_c = 8'd12;  30: sym_c = 8'd3;  31: sym_c = 8'd133;
      32: sym_c = 8'd100;  33: sym_c = 8'd145;  34: sym_c = 8'd34;  35: sym_c = 8'd192;
      36: sym_c = 8'd149;  37: sym_c = 8'd136;  38: sym_c = 8'd90;  39: sym_c = 8'd101;
      40: sym_c = 8'd48;  41: sym_c = 8'd165;  42: sym_c = 8'd74;  43: sym_c = 8'd7;
      44: sym_c = 8'd26;  45: sym_c = 8'd13;  46: sym_c = 8'd19;  47: sym_c = 8'd76;
      48: sym_c = 8'd15;  49: sym_c = 8'd112;  50: sym_c = 8'd102;  51: sym_c = 8'd153;
      52: sym_c = 8'd196;  53: sym_c = 8'd161;  54: sym_c = 8'd49;  55: sym_c = 8'd98;
      56: sym_c = 8'd130;  57: sym_c = 8'd164;  58: sym_c = 8'd208;  59: sym_c = 8'd38;
      60: sym_c = 8'd137;  61: sym_c = 8'd40;  62: sym_c = 8'd67;  63: sym_c = 8'd28;
      64: sym_c = 8'd11;  65: sym_c = 8'd152;  66: sym_c = 8'd14;  67: sym_c = 8'd23;
      68: sym_c = 8'd41;  69: sym_c = 8'd134;  70: sym_c = 8'd193;  71: sym_c = 8'd77;
      72: sym_c = 8'd52;  73: sym_c = 8'd240;  74: sym_c = 8'd104;  75: sym_c = 8'd224;
      76: sym_c = 8'd150;  77: sym_c = 8'd71;  78: sym_c = 8'd146;  79: sym_c = 8'd29;
      80: sym_c = 8'd83;  81: sym_c = 8'd170;  82: sym_c = 8'd105;  83: sym_c = 8'd92;
      84: sym_c = 8'd176;  85: sym_c = 8'd35;  86: sym_c = 8'd113;  87: sym_c = 8'd87;
      88: sym_c = 8'd197;  89: sym_c = 8'd53;  90: sym_c = 8'd209;  91: sym_c = 8'd212;
      92: sym_c = 8'd200;  93: sym_c = 8'd93;  94: sym_c = 8'd95;  95: sym_c = 8'd50;
      96: sym_c = 8'd140;  97: sym_c = 8'd116;  98: sym_c = 8'd154;  99: sym_c = 8'd106;
      100: sym_c = 8'd117;  101: sym_c = 8'd166;  102: sym_c = 8'd94;  103: sym_c = 8'd169;
      104: sym_c = 8'd245;  105: sym_c = 8'd213;  106: sym_c = 8'd91;  107: sym_c = 8'd51;
      108: sym_c = 8'd27;  109: sym_c = 8'd30;  110: sym_c = 8'd78;  111: sym_c = 8'd138;
      112: sym_c = 8'd39;  113: sym_c = 8'd75;  114: sym_c = 8'd42;  115: sym_c = 8'd204;
      116: sym_c = 8'd229;  117: sym_c = 8'd141;  118: sym_c = 8'd168;  119: sym_c = 8'd99;
      120: sym_c = 8'd162;  121: sym_c = 8'd114;  122: sym_c = 8'd103;  123: sym_c = 8'd177;
      124: sym_c = 8'd31;  125: sym_c = 8'd225;  126: sym_c = 8'd54;  127: sym_c = 8'd181;
      128: sym_c = 8'd157;  129: sym_c = 8'd201;  130: sym_c = 8'd228;  131: sym_c = 8'd216;
      132: sym_c = 8'd156;  133: sym_c = 8'd118;  134: sym_c = 8'd79;  135: sym_c = 8'd180;
      136: sym_c = 8'd194;  137: sym_c = 8'd56;  138: sym_c = 8'd131;  139: sym_c = 8'd217;
      140: sym_c = 8'd44;  141: sym_c = 8'd244;  142: sym_c = 8'd158;  143: sym_c = 8'd210;
      144: sym_c = 8'd57;  145: sym_c = 8'd108;  146: sym_c = 8'd45;  147: sym_c = 8'd175;
      148: sym_c = 8'd147;  149: sym_c = 8'd109;  150: sym_c = 8'd241;  151: sym_c = 8'd135;
      152: sym_c = 8'd198;  153: sym_c = 8'd151;  154: sym_c = 8'd119;  155: sym_c = 8'd120;
      156: sym_c = 8'd214;  157: sym_c = 8'd107;  158: sym_c = 8'd121;  159: sym_c = 8'd250;
      160: sym_c = 8'd233;  161: sym_c = 8'd142;  162: sym_c = 8'd182;  163: sym_c = 8'd221;
      164: sym_c = 8'd55;  165: sym_c = 8'd220;  166: sym_c = 8'd43;  167: sym_c = 8'd255;
      168: sym_c = 8'd115;  169: sym_c = 8'd171;  170: sym_c = 8'd155;  171: sym_c = 8'd110;
      172: sym_c = 8'd205;  173: sym_c = 8'd186;  174: sym_c = 8'd173;  175: sym_c = 8'd122;
      176: sym_c = 8'd202;  177: sym_c = 8'd218;  178: sym_c = 8'd58;  179: sym_c = 8'd230;
      180: sym_c = 8'd46;  181: sym_c = 8'd174;  182: sym_c = 8'd195;  183: sym_c = 8'd167;
      184: sym_c = 8'd139;  185: sym_c = 8'd178;  186: sym_c = 8'd185;  187: sym_c = 8'd232;
      188: sym_c = 8'd111;  189: sym_c = 8'd60;  190: sym_c = 8'd234;  191: sym_c = 8'd159;
      192: sym_c = 8'd226;  193: sym_c = 8'd246;  194: sym_c = 8'd184;  195: sym_c = 8'd211;
      196: sym_c = 8'd163;  197: sym_c = 8'd61;  198: sym_c = 8'd123;  199: sym_c = 8'd172;
      200: sym_c = 8'd187;  201: sym_c = 8'd238;  202: sym_c = 8'd249;  203: sym_c = 8'd125;
      204: sym_c = 8'd183;  205: sym_c = 8'd47;  206: sym_c = 8'd143;  207: sym_c = 8'd199;
      208: sym_c = 8'd179;  209: sym_c = 8'd248;  210: sym_c = 8'd124;  211: sym_c = 8'd206;
      212: sym_c = 8'd237;  213: sym_c = 8'd59;  214: sym_c = 8'd239;  215: sym_c = 8'd126;
      216: sym_c = 8'd215;  217: sym_c = 8'd222;  218: sym_c = 8'd251;  219: sym_c = 8'd189;
      220: sym_c = 8'd62;  221: sym_c = 8'd219;  222: sym_c = 8'd254;  223: sym_c = 8'd191;
      224: sym_c = 8'd203;  225: sym_c = 8'd242;  226: sym_c = 8'd231;  227: sym_c = 8'd190;
      228: sym_c = 8'd127;  229: sym_c = 8'd235;  230: sym_c = 8'd236;  231: sym_c = 8'd188;
      232: sym_c = 8'd253;  233: sym_c = 8'd243;  234: sym_c = 8'd227;  235: sym_c = 8'd207;
      236: sym_c = 8'd63;  237: sym_c = 8'd247;  238: sym_c = 8'd223;  239: sym_c = 8'd252;
      default: sym_c = sym_t;
    endcase
  end

  assign sym_sel = (component == ec_pkg::COMP_LUMA) ? sym_l : sym_c;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      symbol   <= '0;
      size     <= '0;
      sample_0 <= '0;
      sample_1 <= '0;
      sample_2 <= '0;
      sample_3 <= '0;
    end
    else
    begin
      symbol   <= sym_sel;
      size     <= size_in;       // Kept in step with the symbol.
      sample_0 <= sym_sel[7:6];  // First sample sits in the MSBs.
      sample_1 <= sym_sel[5:4];
      sample_2 <= sym_sel[3:2];
      sample_3 <= sym_sel[1:0];
    end
  end

  // Table select comes from the stage 1 register.
  a_comp_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(component));

endmodule

//--- src/ec_symbol_decoder.sv
`timescale 1ns/100ps
`include "ec_defines.svh"

module ec_symbol_decoder
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`EC_WINDOW_W-1:0] window,
  input  ec_pkg::component_e      component,
  output ec_pkg::symbol_t         symbol,
  output ec_pkg::size_t           size,
  output ec_pkg::sample_t         sample_0,
  output ec_pkg::sample_t         sample_1,
  output ec_pkg::sample_t         sample_2,
  output ec_pkg::sample_t         sample_3
);

  // Stage 1 results.
  ec_pkg::code_num_t  code_num_s1;
  ec_pkg::size_t      size_s1;
  ec_pkg::component_e component_s1;

  ec_prefix_decoder u_prefix
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .window      (window),
    .component   (component),
    .code_num    (code_num_s1),
    .size        (size_s1),
    .component_q (component_s1)
  );

  ec_symbol_lut u_lut
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .code_num  (code_num_s1),
    .size_in   (size_s1),
    .component (component_s1),
    .symbol    (symbol),
    .size      (size),
    .sample_0  (sample_0),
    .sample_1  (sample_1),
    .sample_2  (sample_2),
    .sample_3  (sample_3)
  );

endmodule

//--- testbench/tb_ec_symbol_decoder.sv
`timescale 1ns/100ps
`include "ec_defines.svh"

module tb_ec_symbol_decoder;

  localparam int    RESET_CYCLES = 10;
  localparam int    MAX_CASES    = 64;
  localparam int    NUM_CASES    = 26;
  localparam string CASES_FILE   = "testbench/ec_symbol_cases.txt";

  logic                    clk;
  logic                    rst_n;
  logic [`EC_WINDOW_W-1:0] window;
  ec_pkg::component_e      component;
  ec_pkg::symbol_t         symbol;
  ec_pkg::size_t           size;
  ec_pkg::sample_t         sample_0;
  ec_pkg::sample_t         sample_1;
  ec_pkg::sample_t         sample_2;
  ec_pkg::sample_t         sample_3;

  ec_pkg::component_e      case_comp [MAX_CASES];
  logic [`EC_WINDOW_W-1:0] case_window [MAX_CASES];
  int                      case_size [MAX_CASES];
  int                      case_symbol [MAX_CASES];
  logic [7:0]              case_samples [MAX_CASES];  // Four 2-bit samples, sample_0 in MSBs.

  int n_cases;
  int errors;
  int checks;
  int cycle_cnt;
  int cycle_limit;
  int pending [$];  // Case indices in flight.

  ec_symbol_decoder uut
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .window    (window),
    .component (component),
    .symbol    (symbol),
    .size      (size),
    .sample_0  (sample_0),
    .sample_1  (sample_1),
    .sample_2  (sample_2),
    .sample_3  (sample_3)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // Size from the leading ones rule.
  function automatic int rule_size(input logic [`EC_WINDOW_W-1:0] w);
    int ones;
    ones = 0;
    while (ones < `EC_MAX_PREFIX && w[`EC_WINDOW_W-1-ones])
      ones++;
    if (ones == `EC_MAX_PREFIX)
      return ones + `EC_GRK;  // No stop bit at the clip.
    else
      return ones + 1 + `EC_GRK;
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    int          comp_val;
    int          s0;
    int          s1;
    int          s2;
    int          s3;
    logic [31:0] win_val;
    string       line;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the cases file %s", CASES_FILE);
      errors++;
      return;
    end
    while (n_cases < MAX_CASES)
    begin
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%d %h %d %d %d %d %d %d", comp_val, win_val,
                  case_size[n_cases], case_symbol[n_cases], s0, s1, s2, s3);
      if (n != 8)
      begin
        $display("Cases file has a line that cannot be parsed: %s", line);
        errors++;
        continue;
      end
      case_comp[n_cases]    = (comp_val != 0) ? ec_pkg::COMP_LUMA : ec_pkg::COMP_CHROMA;
      case_window[n_cases]  = win_val[`EC_WINDOW_W-1:0];
      case_samples[n_cases] = {2'(s0), 2'(s1), 2'(s2), 2'(s3)};
      n_cases++;
    end
    $fclose(fd);
    if (n_cases < NUM_CASES)
    begin
      $display("Cases file is short: read %0d of %0d cases", n_cases, NUM_CASES);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    checks++;
    if ({symbol, size, sample_0, sample_1, sample_2, sample_3} !== '0)
    begin
      errors++;
      $display("FAILED at %0t: outputs not zero after reset (symbol %0d size %0d)",
               $time, symbol, size);
    end
  endtask

  task automatic check_case(input int idx);
    logic [7:0] got_samples;
    int         exp_size;
    got_samples = {sample_0, sample_1, sample_2, sample_3};
    exp_size    = rule_size(case_window[idx]);
    checks++;
    if (case_size[idx] != exp_size)
    begin
      errors++;
      $display("Cases file gives size %0d for case %0d, the decode rule gives %0d",
               case_size[idx], idx, exp_size);
    end
    if (symbol !== 8'(case_symbol[idx]))
    begin
      errors++;
      $display("FAILED at %0t: case %0d window %h symbol %0d, expected %0d",
               $time, idx, case_window[idx], symbol, case_symbol[idx]);
    end
    if (size !== 4'(exp_size))
    begin
      errors++;
      $display("FAILED at %0t: case %0d size %0d, expected %0d", $time, idx, size, exp_size);
    end
    if (got_samples !== case_samples[idx])
    begin
      errors++;
      $display("FAILED at %0t: case %0d samples %h, expected %h",
               $time, idx, got_samples, case_samples[idx]);
    end
    if (got_samples !== symbol)
    begin
      errors++;
      $display("FAILED at %0t: case %0d samples %h do not match symbol %h",
               $time, idx, got_samples, symbol);
    end
  endtask

  task automatic run_cases();
    for (int cyc = 0; cyc < n_cases + 2; cyc++)
    begin
      @(posedge clk);
      if (cyc < n_cases)
      begin
        window    <= case_window[cyc];
        component <= case_comp[cyc];
        pending.push_back(cyc);
      end
      @(negedge clk);
      if (cyc >= 2)
        check_case(pending.pop_front());  // Two stages behind the drive.
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    window      = '0;
    component   = ec_pkg::COMP_CHROMA;
    n_cases     = 0;
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    cycle_limit = RESET_CYCLES + 20;
    load_cases();
    cycle_limit = RESET_CYCLES + n_cases + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();
    if (n_cases >= NUM_CASES)
      run_cases();
    $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- testbench/ec_symbol_cases.txt
# component (0 chroma, 1 luma), window (hex), size, symbol, sample_0 .. sample_3
# Symbols taken from the luma and chroma inverse tables.
1 0000 6 8 0 0 2 0
0 0000 6 2 0 0 0 2
1 7C00 6 100 1 2 1 0
0 17FF 6 9 0 0 2 1
1 8000 7 86 1 1 1 2
0 8700 7 192 3 0 0 0
1 CA00 8 113 1 3 0 1
0 CA00 8 104 1 2 2 0
1 E880 9 54 0 3 1 2
0 E000 9 140 2 0 3 0
1 F0C0 10 103 1 2 1 3
0 F7C0 10 250 3 3 2 2
1 F980 11 155 2 1 2 3
0 F820 11 142 2 0 3 2
1 FD50 12 123 1 3 2 3
0 FC80 12 187 2 3 2 3
1 FE00 12 207 3 0 3 3
0 FE00 12 203 3 0 2 3
1 FF60 12 65 1 0 0 1
0 FFFF 12 0 0 0 0 0
1 FEF0 12 251 3 3 2 3
0 FEF0 12 252 3 3 3 0
1 FF00 12 85 1 1 1 1
0 FF00 12 85 1 1 1 1
1 0400 6 2 0 0 0 2
0 0400 6 8 0 0 2 0

//--- compile.f
+incdir+src
src/ec_pkg.sv
src/ec_prefix_decoder.sv
src/ec_symbol_lut.sv
src/ec_symbol_decoder.sv
testbench/tb_ec_symbol_decoder.sv
